//--- verilog/usb_dfu_pkg.sv
`default_nettype none

package usb_dfu_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] word_t;
  typedef logic [6:0]  dev_addr_t;

  typedef enum logic [7:0] {
    STATE_APP_IDLE                = 8'h00,
    STATE_APP_DETACH              = 8'h01,
    STATE_DFU_IDLE                = 8'h02,
    STATE_DFU_DNLOAD_SYNC         = 8'h03,
    STATE_DFU_DNBUSY              = 8'h04,
    STATE_DFU_DNLOAD_IDLE         = 8'h05,
    STATE_DFU_MANIFEST_SYNC       = 8'h06,
    STATE_DFU_MANIFEST            = 8'h07,
    STATE_DFU_MANIFEST_WAIT_RESET = 8'h08,
    STATE_DFU_UPLOAD_IDLE         = 8'h09,
    STATE_DFU_ERROR               = 8'h0a
  } dfu_state_e;

  typedef enum logic [7:0] {
    STATUS_OK         = 8'h00,
    STATUS_ERR_TARGET = 8'h01
  } dfu_status_e;

  typedef enum logic {
    SRC_DEVICE_DESC = 1'b0,
    SRC_DFU_STATUS  = 1'b1
  } in_src_e;

  ////////////////////////////////////////
  // request codes, {bmRequestType[6:5], bRequest}
  localparam logic [9:0] REQ_GET_DESCRIPTOR    = 10'h006;
  localparam logic [9:0] REQ_SET_ADDRESS       = 10'h005;
  localparam logic [9:0] REQ_SET_CONFIGURATION = 10'h009;
  localparam logic [9:0] REQ_DFU_DETACH        = 10'h100;
  localparam logic [9:0] REQ_DFU_DNLOAD        = 10'h101;
  localparam logic [9:0] REQ_DFU_UPLOAD        = 10'h102;
  localparam logic [9:0] REQ_DFU_GETSTATUS     = 10'h103;
  localparam logic [9:0] REQ_DFU_CLRSTATUS     = 10'h104;
  localparam logic [9:0] REQ_DFU_GETSTATE      = 10'h105;
  localparam logic [9:0] REQ_DFU_ABORT         = 10'h106;

  localparam byte_t DESC_TYPE_DEVICE = 8'd1;

  ////////////////////////////////////////
  // device descriptor
  localparam word_t VENDOR_ID  = 16'h1209;
  localparam word_t PRODUCT_ID = 16'h70b1;

  localparam word_t DEVICE_DESC_LEN = 16'd18;
  localparam byte_t DEVICE_DESC [0:17] = '{
    8'd18, 8'd1,                        // bLength, bDescriptorType
    8'h00, 8'h01,                       // bcdUSB
    8'h00, 8'h00, 8'h00,                // class, subclass, protocol
    8'h00,                              // bMaxPacketSize0, filled in by the IN source
    VENDOR_ID[7:0], VENDOR_ID[15:8],
    PRODUCT_ID[7:0], PRODUCT_ID[15:8],
    8'h00, 8'h00,                       // bcdDevice
    8'd1, 8'd2, 8'd3,                   // manufacturer, product, serial string idx
    8'd1                                // bNumConfigurations
  };
  localparam int DESC_MAX_PKT_IDX = 7;

  // GETSTATUS reply fields
  localparam word_t           DFU_STATUS_LEN   = 16'd6;
  localparam logic [23:0]     DFU_POLL_TIMEOUT = 24'd1;
  localparam byte_t           DFU_ISTRING      = 8'd0;

endpackage

`default_nettype wire

//--- verilog/setup_if.sv
`default_nettype none

interface setup_if;
  import usb_dfu_pkg::*;

  byte_t bm_request_type;
  byte_t b_request;
  word_t w_value;
  word_t w_length;

  modport capture (output bm_request_type, b_request, w_value, w_length);
  modport fsm     (input bm_request_type, w_length);
  modport decoder (input bm_request_type, b_request, w_value, w_length);

endinterface

`default_nettype wire

//--- verilog/in_load_if.sv
`default_nettype none

interface in_load_if;
  import usb_dfu_pkg::*;

  logic    load;        // one-cycle start pulse
  in_src_e src;
  byte_t   start_addr;
  word_t   length;      // already clipped to wLength

  modport request (output load, src, start_addr, length);
  modport source  (input load, src, start_addr, length);

endinterface

`default_nettype wire

//--- verilog/setup_capture.sv
`default_nettype none

module setup_capture (
  input  logic               clk,
  input  logic               reset,
  input  logic               out_ep_setup,
  input  usb_dfu_pkg::byte_t out_ep_data,
  input  logic               out_ep_data_valid,
  setup_if.capture           setup
);
  import usb_dfu_pkg::*;

  byte_t      setup_mem [8];
  logic [2:0] wr_ptr;

  // pointer sits at zero between setup packets, wraps after 8 bytes
  always_ff @(posedge clk) begin
    if (reset || !out_ep_setup) begin
      wr_ptr <= '0;
    end else if (out_ep_data_valid) begin
      wr_ptr <= wr_ptr + 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (out_ep_setup && out_ep_data_valid) begin
      setup_mem[wr_ptr] <= out_ep_data;
    end
  end

  // little-endian fields, wIndex is not needed here
  assign setup.bm_request_type = setup_mem[0];
  assign setup.b_request       = setup_mem[1];
  assign setup.w_value         = {setup_mem[3], setup_mem[2]};
  assign setup.w_length        = {setup_mem[7], setup_mem[6]};

endmodule

`default_nettype wire

//--- verilog/ctrl_xfr_fsm.sv
`default_nettype none

module ctrl_xfr_fsm (
  input  logic  clk,
  input  logic  reset,
  input  logic  out_ep_data_avail,
  input  logic  out_ep_setup,
  input  logic  out_ep_grant,
  input  logic  in_ep_acked,
  input  logic  out_ep_acked,
  input  logic  in_ep_stall,
  input  logic  all_sent,
  setup_if.fsm  setup,
  output logic  setup_stage_end,
  output logic  status_stage_end,
  output logic  in_stage,
  output logic  in_ep_data_done_zlp,
  output logic  out_ep_data_get
);
  import usb_dfu_pkg::*;

  typedef enum logic [2:0] {
    IDLE, SETUP_IN, SETUP_DONE, DATA_IN, DATA_OUT, STATUS_IN, STATUS_OUT
  } ctrl_state_e;

  ctrl_state_e state;
  ctrl_state_e state_next;
  logic        avail_q;
  word_t       out_remaining;   // OUT bytes still to drain

  wire pkt_start      = out_ep_data_avail && !avail_q;
  wire pkt_end        = !out_ep_data_avail && avail_q;
  wire has_data_stage = |setup.w_length;
  wire out_byte       = out_ep_grant && out_ep_data_get && !out_ep_setup;

  assign out_ep_data_get = out_ep_data_avail;   // drain anything offered
  assign in_stage        = (state == DATA_IN);

  always_comb begin
    state_next          = state;
    setup_stage_end     = 1'b0;
    status_stage_end    = 1'b0;
    in_ep_data_done_zlp = 1'b0;
    case (state)
      IDLE: if (pkt_start && out_ep_setup) state_next = SETUP_IN;
      SETUP_IN: if (pkt_end) state_next = SETUP_DONE;
      SETUP_DONE: begin
        setup_stage_end = 1'b1;
        if (has_data_stage && setup.bm_request_type[7]) begin
          state_next = DATA_IN;
        end else if (has_data_stage) begin
          state_next = DATA_OUT;
        end else begin
          state_next          = STATUS_IN;
          in_ep_data_done_zlp = 1'b1;   // no data stage
        end
      end
      DATA_IN: if (in_ep_acked && all_sent) state_next = STATUS_OUT;
      DATA_OUT: begin
        if (out_remaining == '0) begin
          state_next          = STATUS_IN;
          in_ep_data_done_zlp = 1'b1;
        end
      end
      STATUS_IN, STATUS_OUT: begin
        if ((state == STATUS_IN) ? in_ep_acked : out_ep_acked) begin
          state_next       = IDLE;
          status_stage_end = 1'b1;
        end
      end
      default: state_next = IDLE;
    endcase

    // a stalled request abandons the transfer
    if (in_ep_stall && (state == DATA_IN || state == DATA_OUT || state == STATUS_IN)) begin
      state_next       = IDLE;
      status_stage_end = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= IDLE;
      avail_q       <= 1'b0;
      out_remaining <= '0;
    end else begin
      state   <= state_next;
      avail_q <= out_ep_data_avail;
      if (state == SETUP_DONE) begin
        out_remaining <= setup.w_length;
      end else if (state == DATA_OUT && out_byte && out_remaining != '0) begin
        out_remaining <= out_remaining - 16'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/dfu_request_unit.sv
`default_nettype none

module dfu_request_unit (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     setup_stage_end,
  input  logic                     status_stage_end,
  setup_if.decoder                 setup,
  in_load_if.request               load,
  output usb_dfu_pkg::dfu_state_e  dfu_state,
  output usb_dfu_pkg::dfu_status_e dfu_status,
  output usb_dfu_pkg::dev_addr_t   dev_addr,
  output logic                     in_ep_stall
);
  import usb_dfu_pkg::*;

  logic      addr_pending;   // SET_ADDRESS waiting for its status stage
  dev_addr_t new_addr;

  wire [9:0] req_code = {setup.bm_request_type[6:5], setup.b_request};

  function automatic word_t clip_len(word_t requested, word_t available);
    return (requested < available) ? requested : available;
  endfunction

  // IN source selection, refreshed on every setup packet
  always_ff @(posedge clk) begin
    if (setup_stage_end) begin
      load.src        <= SRC_DEVICE_DESC;
      load.start_addr <= 8'd0;
      load.length     <= '0;
      if (req_code == REQ_GET_DESCRIPTOR && setup.w_value[15:8] == DESC_TYPE_DEVICE) begin
        load.length <= clip_len(setup.w_length, DEVICE_DESC_LEN);
      end else if (req_code == REQ_DFU_GETSTATUS) begin
        load.src    <= SRC_DFU_STATUS;
        load.length <= clip_len(setup.w_length, DFU_STATUS_LEN);
      end else if (req_code == REQ_DFU_GETSTATE) begin
        load.src        <= SRC_DFU_STATUS;
        load.start_addr <= 8'd4;   // bState only
        load.length     <= clip_len(setup.w_length, 16'd1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      load.load    <= 1'b0;
      in_ep_stall  <= 1'b0;
      dfu_state    <= STATE_APP_IDLE;
      dfu_status   <= STATUS_OK;
      dev_addr     <= '0;
      addr_pending <= 1'b0;
      new_addr     <= '0;
    end else begin
      load.load   <= setup_stage_end;
      in_ep_stall <= 1'b0;
      if (setup_stage_end) begin
        case (req_code)
          REQ_GET_DESCRIPTOR: begin
            // only the device descriptor is served
            in_ep_stall <= (setup.w_value[15:8] != DESC_TYPE_DEVICE);
          end
          REQ_SET_ADDRESS: begin
            addr_pending <= 1'b1;
            new_addr     <= setup.w_value[6:0];
          end
          REQ_SET_CONFIGURATION: begin
            dfu_state <= (|setup.w_value) ? STATE_DFU_IDLE : STATE_APP_IDLE;
          end
          REQ_DFU_DETACH: dfu_state <= STATE_APP_DETACH;
          REQ_DFU_DNLOAD, REQ_DFU_UPLOAD: begin
            dfu_status <= STATUS_ERR_TARGET;   // no flash behind us
            dfu_state  <= STATE_DFU_ERROR;
          end
          REQ_DFU_CLRSTATUS: begin
            dfu_status <= STATUS_OK;
            dfu_state  <= STATE_DFU_IDLE;
          end
          REQ_DFU_ABORT: dfu_state <= STATE_DFU_IDLE;
          default: ;
        endcase
      end
      // old address still answers the status stage
      if (status_stage_end) begin
        addr_pending <= 1'b0;
        if (addr_pending) dev_addr <= new_addr;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/in_data_source.sv
`default_nettype none

module in_data_source #(
  parameter int MAX_PACKET_SIZE = 32
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     in_stage,
  input  logic                     in_ep_grant,
  input  logic                     in_ep_data_free,
  in_load_if.source                load,
  input  usb_dfu_pkg::dfu_state_e  dfu_state,
  input  usb_dfu_pkg::dfu_status_e dfu_status,
  output logic                     in_ep_req,
  output logic                     in_ep_data_put,
  output logic                     in_ep_data_done_last,
  output logic                     all_sent,
  output usb_dfu_pkg::byte_t       in_ep_data
);
  import usb_dfu_pkg::*;

  in_src_e src;
  byte_t   rd_addr;
  word_t   remaining;
  logic    sent_q;

  assign all_sent       = (remaining == '0);
  assign in_ep_req      = in_stage && !all_sent;
  assign in_ep_data_put = in_ep_req && in_ep_data_free;   // held under back-pressure

  // single done pulse once the last byte has gone
  // the load cycle still sees the old count and is skipped
  assign in_ep_data_done_last = in_stage && all_sent && !sent_q && !load.load;

  always_ff @(posedge clk) begin
    if (reset) begin
      src       <= SRC_DEVICE_DESC;
      rd_addr   <= '0;
      remaining <= '0;
      sent_q    <= 1'b0;
    end else begin
      sent_q <= in_stage && all_sent && !load.load;
      if (load.load) begin
        src       <= load.src;
        rd_addr   <= load.start_addr;
        remaining <= load.length;
      end else if (in_ep_grant && in_ep_data_put) begin
        rd_addr   <= rd_addr + 8'd1;
        remaining <= remaining - 16'd1;
      end
    end
  end

  ////////////////////////////////////////
  // byte select
  always_comb begin
    in_ep_data = 8'h00;
    if (src == SRC_DEVICE_DESC) begin
      if (rd_addr == byte_t'(DESC_MAX_PKT_IDX)) begin
        in_ep_data = byte_t'(MAX_PACKET_SIZE);
      end else if ({8'h00, rd_addr} < DEVICE_DESC_LEN) begin
        in_ep_data = DEVICE_DESC[rd_addr[4:0]];
      end
    end else begin
      case (rd_addr[2:0])
        3'd0: in_ep_data = dfu_status;                // bStatus
        3'd1: in_ep_data = DFU_POLL_TIMEOUT[7:0];
        3'd2: in_ep_data = DFU_POLL_TIMEOUT[15:8];
        3'd3: in_ep_data = DFU_POLL_TIMEOUT[23:16];
        3'd4: in_ep_data = dfu_state;                 // bState
        3'd5: in_ep_data = DFU_ISTRING;
        default: in_ep_data = 8'h00;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/detach_timer.sv
`default_nettype none

module detach_timer #(
  parameter int CLKS_PER_MS       = 48000,
  parameter int DETACH_TIMEOUT_MS = 1000
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    usb_reset,
  input  usb_dfu_pkg::dfu_state_e dfu_state,
  output logic                    dfu_detach
);
  import usb_dfu_pkg::*;

  localparam int PRE_W = $clog2(CLKS_PER_MS + 1);
  localparam int MS_W  = $clog2(DETACH_TIMEOUT_MS + 1);

  logic [PRE_W-1:0] pre_cnt;
  logic [MS_W-1:0]  ms_left;

  wire ms_tick = (pre_cnt == PRE_W'(CLKS_PER_MS - 1));

  always_ff @(posedge clk) begin
    if (reset || ms_tick) pre_cnt <= '0;
    else pre_cnt <= pre_cnt + 1'b1;
  end

  // countdown only runs in appDETACH, one extra tick so a partial first ms never counts
  always_ff @(posedge clk) begin
    if (reset) begin
      ms_left    <= MS_W'(DETACH_TIMEOUT_MS);
      dfu_detach <= 1'b0;
    end else begin
      if (dfu_state != STATE_APP_DETACH) begin
        ms_left <= MS_W'(DETACH_TIMEOUT_MS);
      end else if (ms_tick) begin
        if (ms_left == '0) dfu_detach <= 1'b1;
        else ms_left <= ms_left - 1'b1;
      end
      if (usb_reset && dfu_state != STATE_APP_IDLE) dfu_detach <= 1'b1;   // sticky
    end
  end

endmodule

`default_nettype wire

//--- verilog/usb_dfu_ctrl_ep.sv
`default_nettype none

module usb_dfu_ctrl_ep #(
  parameter int MAX_PACKET_SIZE   = 32,
  parameter int CLKS_PER_MS       = 48000,
  parameter int DETACH_TIMEOUT_MS = 1000
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   usb_reset,
  output usb_dfu_pkg::dev_addr_t dev_addr,

  ////////////////////////////////////////
  // out endpoint
  output logic                   out_ep_req,
  input  logic                   out_ep_grant,
  input  logic                   out_ep_data_avail,
  input  logic                   out_ep_setup,
  output logic                   out_ep_data_get,
  input  usb_dfu_pkg::byte_t     out_ep_data,
  output logic                   out_ep_stall,
  input  logic                   out_ep_acked,

  ////////////////////////////////////////
  // in endpoint
  output logic                   in_ep_req,
  input  logic                   in_ep_grant,
  input  logic                   in_ep_data_free,
  output logic                   in_ep_data_put,
  output usb_dfu_pkg::byte_t     in_ep_data,
  output logic                   in_ep_data_done,
  output logic                   in_ep_stall,
  input  logic                   in_ep_acked,

  output usb_dfu_pkg::byte_t     dfu_state,
  output logic                   dfu_detach
);
  import usb_dfu_pkg::*;

  logic        out_ep_data_valid;
  logic        setup_stage_end;
  logic        status_stage_end;
  logic        in_stage;
  logic        all_sent;
  logic        done_zlp;
  logic        done_last;
  dfu_state_e  cur_state;
  dfu_status_e cur_status;

  setup_if   setup_bus ();
  in_load_if in_load ();

  assign out_ep_req      = out_ep_data_avail;
  assign out_ep_stall    = 1'b0;   // control OUT never stalls
  assign in_ep_data_done = done_zlp || done_last;
  assign dfu_state       = cur_state;

  // byte on out_ep_data is valid the cycle after its grant
  always_ff @(posedge clk) begin
    if (reset) out_ep_data_valid <= 1'b0;
    else out_ep_data_valid <= out_ep_data_avail && out_ep_grant;
  end

  setup_capture u_setup_capture (
    .clk               (clk),
    .reset             (reset),
    .out_ep_setup      (out_ep_setup),
    .out_ep_data       (out_ep_data),
    .out_ep_data_valid (out_ep_data_valid),
    .setup             (setup_bus.capture)
  );

  ctrl_xfr_fsm u_ctrl_xfr_fsm (
    .clk                 (clk),
    .reset               (reset),
    .out_ep_data_avail   (out_ep_data_avail),
    .out_ep_setup        (out_ep_setup),
    .out_ep_grant        (out_ep_grant),
    .in_ep_acked         (in_ep_acked),
    .out_ep_acked        (out_ep_acked),
    .in_ep_stall         (in_ep_stall),
    .all_sent            (all_sent),
    .setup               (setup_bus.fsm),
    .setup_stage_end     (setup_stage_end),
    .status_stage_end    (status_stage_end),
    .in_stage            (in_stage),
    .in_ep_data_done_zlp (done_zlp),
    .out_ep_data_get     (out_ep_data_get)
  );

  dfu_request_unit u_dfu_request_unit (
    .clk              (clk),
    .reset            (reset),
    .setup_stage_end  (setup_stage_end),
    .status_stage_end (status_stage_end),
    .setup            (setup_bus.decoder),
    .load             (in_load.request),
    .dfu_state        (cur_state),
    .dfu_status       (cur_status),
    .dev_addr         (dev_addr),
    .in_ep_stall      (in_ep_stall)
  );

  in_data_source #(
    .MAX_PACKET_SIZE (MAX_PACKET_SIZE)
  ) u_in_data_source (
    .clk                  (clk),
    .reset                (reset),
    .in_stage             (in_stage),
    .in_ep_grant          (in_ep_grant),
    .in_ep_data_free      (in_ep_data_free),
    .load                 (in_load.source),
    .dfu_state            (cur_state),
    .dfu_status           (cur_status),
    .in_ep_req            (in_ep_req),
    .in_ep_data_put       (in_ep_data_put),
    .in_ep_data_done_last (done_last),
    .all_sent             (all_sent),
    .in_ep_data           (in_ep_data)
  );

  detach_timer #(
    .CLKS_PER_MS       (CLKS_PER_MS),
    .DETACH_TIMEOUT_MS (DETACH_TIMEOUT_MS)
  ) u_detach_timer (
    .clk        (clk),
    .reset      (reset),
    .usb_reset  (usb_reset),
    .dfu_state  (cur_state),
    .dfu_detach (dfu_detach)
  );

endmodule

`default_nettype wire

//--- tests/usb_dfu_ctrl_ep_checker.sv
`default_nettype none

module usb_dfu_ctrl_ep_checker (
  input wire logic       clk,
  input wire logic       reset,
  input wire logic       in_ep_req,
  input wire logic       in_ep_data_free,
  input wire logic [7:0] in_ep_data,
  input wire logic       in_ep_acked,
  input wire logic [6:0] dev_addr,
  input wire logic [7:0] dfu_state,
  input wire logic       dfu_detach
);
  timeunit 1ns;
  timeprecision 1ns;

  ////////////////////////////////////////
  // IN endpoint handshake

  // back-pressure holds the byte and the count
  hold_under_backpressure: assert property (
    @(posedge clk) disable iff (reset)
    (in_ep_req && !in_ep_data_free) |=> (in_ep_req && $stable(in_ep_data))
  ) else $error("IN byte or count moved while in_ep_data_free was low");

  ////////////////////////////////////////
  // DFU registers

  // sticky until reset
  detach_sticky: assert property (
    @(posedge clk) disable iff (reset)
    !$fell(dfu_detach)
  ) else $error("dfu_detach fell outside reset");

  addr_after_ack: assert property (
    @(posedge clk) disable iff (reset)
    $changed(dev_addr) |-> $past(in_ep_acked)
  ) else $error("dev_addr changed without a preceding in_ep_acked");

  state_legal: assert property (
    @(posedge clk) disable iff (reset)
    dfu_state <= 8'd10   // appIDLE .. dfuERROR
  ) else $error("dfu_state holds an illegal code");

endmodule

bind usb_dfu_ctrl_ep usb_dfu_ctrl_ep_checker u_checker (
  .clk             (clk),
  .reset           (reset),
  .in_ep_req       (in_ep_req),
  .in_ep_data_free (in_ep_data_free),
  .in_ep_data      (in_ep_data),
  .in_ep_acked     (in_ep_acked),
  .dev_addr        (dev_addr),
  .dfu_state       (dfu_state),
  .dfu_detach      (dfu_detach)
);

`default_nettype wire

//--- tests/usb_dfu_ctrl_ep_tb.sv
`default_nettype none

module usb_dfu_ctrl_ep_tb;
  timeunit 1ns;
  timeprecision 1ns;
  import usb_dfu_pkg::*;

  localparam int CLKS_PER_MS       = 4;
  localparam int DETACH_TIMEOUT_MS = 5;
  localparam int WATCHDOG_CYCLES   = 4000;   // far above the length of all transfers

  logic      clk;
  logic      reset;
  logic      usb_reset;
  dev_addr_t dev_addr;
  logic      out_ep_req;
  logic      out_ep_grant;
  logic      out_ep_data_avail;
  logic      out_ep_setup;
  logic      out_ep_data_get;
  byte_t     out_ep_data;
  logic      out_ep_stall;
  logic      out_ep_acked;
  logic      in_ep_req;
  logic      in_ep_grant;
  logic      in_ep_data_free;
  logic      in_ep_data_put;
  byte_t     in_ep_data;
  logic      in_ep_data_done;
  logic      in_ep_stall;
  logic      in_ep_acked;
  byte_t     dfu_state;
  logic      dfu_detach;

  byte_t rx [$];   // bytes of the last IN data stage
  int    detach_cycles;

  usb_dfu_ctrl_ep #(
    .MAX_PACKET_SIZE   (32),
    .CLKS_PER_MS       (CLKS_PER_MS),
    .DETACH_TIMEOUT_MS (DETACH_TIMEOUT_MS)
  ) DUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  end

  ////////////////////////////////////////
  // check helpers

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input int got, input int exp);
    assert (got == exp)
      else fail_now($sformatf("MISMATCH t=%0t %s got 0x%0h expected 0x%0h",
                              $time, name, got, exp));
  endtask

  task automatic check_reply(input int exp [$]);
    check_val("IN byte count", rx.size(), exp.size());
    foreach (exp[i]) check_val($sformatf("in_ep_data[%0d]", i), int'(rx[i]), exp[i]);
  endtask

  ////////////////////////////////////////
  // host side of the endpoints

  // data lags its grant by one cycle
  task automatic send_setup(input byte_t bm, input byte_t req, input word_t val,
                            input word_t len);
    byte_t pkt [8];
    pkt = '{bm, req, val[7:0], val[15:8], 8'h00, 8'h00, len[7:0], len[15:8]};
    for (int i = 0; i <= 8; i++) begin
      @(negedge clk);
      out_ep_setup      = 1'b1;
      out_ep_data_avail = (i < 8);
      out_ep_grant      = (i < 8);
      if (i > 0) out_ep_data = pkt[i-1];
      #5;
      check_val("out_ep_req", int'(out_ep_req), int'(out_ep_data_avail));
    end
    @(negedge clk);
    out_ep_setup = 1'b0;
  endtask

  task automatic send_out(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      out_ep_data_avail = 1'b1;
      out_ep_grant      = 1'b1;
      out_ep_data       = byte_t'(i) + 8'h50;
      #5;
      check_val("out_ep_data_get", int'(out_ep_data_get), 1);
    end
    @(negedge clk);
    out_ep_data_avail = 1'b0;
    out_ep_grant      = 1'b0;
  endtask

  // zero-length status packet leaves the device
  task automatic wait_status_zlp();
    int n;
    n = 0;
    #5;
    while (!in_ep_data_done) begin
      @(negedge clk);
      #5;
      n++;
      if (n > 20) fail_now("in_ep_data_done did not pulse for the status stage");
    end
  endtask

  // zero-length status packet and the host ack
  task automatic status_in_ack();
    wait_status_zlp();
    @(negedge clk);
    in_ep_acked = 1'b1;
    @(negedge clk);
    in_ep_acked = 1'b0;
  endtask

  task automatic read_in();
    int   n;
    int   done_cnt;
    logic started;
    n        = 0;
    done_cnt = 0;
    started  = 1'b0;
    rx.delete();
    while (1) begin
      @(negedge clk);
      in_ep_grant     = 1'b1;
      in_ep_data_free = ($urandom % 4) != 0;   // random back-pressure
      #5;
      if (in_ep_req) started = 1'b1;
      if (in_ep_data_put) rx.push_back(in_ep_data);
      if (in_ep_data_done) done_cnt++;
      if (started && !in_ep_req) break;
      n++;
      if (n > 200) fail_now("IN data stage did not finish");
    end
    // done follows the last granted byte by one cycle
    check_val("in_ep_data_done", int'(in_ep_data_done), 1);
    check_val("in_ep_data_done pulse count", done_cnt, 1);
    @(negedge clk);
    in_ep_grant     = 1'b0;
    in_ep_data_free = 1'b0;
    in_ep_acked     = 1'b1;
    @(negedge clk);
    in_ep_acked  = 1'b0;
    out_ep_acked = 1'b1;
    @(negedge clk);
    out_ep_acked = 1'b0;
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (8) @(negedge clk);
    reset = 1'b0;
  endtask

  ////////////////////////////////////////
  // main sequence

  initial begin
    int exp_desc [$];
    logic seen;
    void'($urandom(35));
    reset             = 1'b1;
    usb_reset         = 1'b0;
    out_ep_grant      = 1'b0;
    out_ep_data_avail = 1'b0;
    out_ep_setup      = 1'b0;
    out_ep_data       = 8'h00;
    out_ep_acked      = 1'b0;
    in_ep_grant       = 1'b0;
    in_ep_data_free   = 1'b0;
    in_ep_acked       = 1'b0;
    apply_reset();
    #5;
    check_val("in_ep_req", int'(in_ep_req), 0);
    check_val("in_ep_data_put", int'(in_ep_data_put), 0);
    check_val("in_ep_data_done", int'(in_ep_data_done), 0);
    check_val("in_ep_stall", int'(in_ep_stall), 0);
    check_val("out_ep_stall", int'(out_ep_stall), 0);
    check_val("dfu_detach", int'(dfu_detach), 0);
    check_val("dev_addr", int'(dev_addr), 0);
    check_val("dfu_state", int'(dfu_state), 0);

    // device descriptor in full and clipped to 8 bytes
    for (int i = 0; i < 18; i++) exp_desc.push_back((i == 7) ? 32 : int'(DEVICE_DESC[i]));
    send_setup(8'h80, 8'h06, 16'h0100, 16'd64);
    read_in();
    check_reply(exp_desc);
    send_setup(8'h80, 8'h06, 16'h0100, 16'd8);
    read_in();
    check_reply(exp_desc[0:7]);

    // device qualifier is not served
    send_setup(8'h80, 8'h06, 16'h0600, 16'd10);
    seen = 1'b0;
    repeat (5) begin
      #5;
      if (in_ep_stall) seen = 1'b1;
      @(negedge clk);
    end
    check_val("in_ep_stall", int'(seen), 1);

    send_setup(8'h00, 8'h05, 16'h002a, 16'd0);
    wait_status_zlp();
    check_val("dev_addr", int'(dev_addr), 0);
    @(negedge clk);
    in_ep_acked = 1'b1;
    #5;
    check_val("dev_addr", int'(dev_addr), 0);   // old address answers the ack
    @(negedge clk);
    in_ep_acked = 1'b0;
    #5;
    check_val("dev_addr", int'(dev_addr), 8'h2a);

    send_setup(8'h00, 8'h09, 16'h0001, 16'd0);
    status_in_ack();
    check_val("dfu_state", int'(dfu_state), 2);
    send_setup(8'ha1, 8'h03, 16'h0000, 16'd6);
    read_in();
    check_reply('{0, 1, 0, 0, 2, 0});
    send_setup(8'ha1, 8'h05, 16'h0000, 16'd1);
    read_in();
    check_reply('{2});

    // rejected download still drains its data
    send_setup(8'h21, 8'h01, 16'h0000, 16'd4);
    send_out(4);
    status_in_ack();
    check_val("dfu_state", int'(dfu_state), 10);
    send_setup(8'ha1, 8'h03, 16'h0000, 16'd6);
    read_in();
    check_reply('{1, 1, 0, 0, 10, 0});
    send_setup(8'h21, 8'h04, 16'h0000, 16'd0);
    status_in_ack();
    check_val("dfu_state", int'(dfu_state), 2);
    send_setup(8'ha1, 8'h03, 16'h0000, 16'd6);
    read_in();
    check_reply('{0, 1, 0, 0, 2, 0});
    send_setup(8'h21, 8'h06, 16'h0000, 16'd0);
    status_in_ack();
    check_val("dfu_state", int'(dfu_state), 2);

    ////////////////////////////////////////
    // detach by timer
    send_setup(8'h21, 8'h00, 16'd1000, 16'd0);
    fork
      status_in_ack();
      begin
        #5;
        while (dfu_state != 8'd1) begin
          @(negedge clk);
          #5;
        end
        detach_cycles = 0;
        while (!dfu_detach) begin
          @(negedge clk);
          #5;
          detach_cycles++;
          if (detach_cycles > 40) fail_now("dfu_detach did not rise in appDETACH");
        end
      end
    join
    assert (detach_cycles >= CLKS_PER_MS * DETACH_TIMEOUT_MS &&
            detach_cycles <= CLKS_PER_MS * (DETACH_TIMEOUT_MS + 2))
      else fail_now($sformatf("dfu_detach rose after %0d cycles, outside the allowed window",
                              detach_cycles));

    // detach by bus reset
    @(negedge clk);
    apply_reset();
    send_setup(8'h00, 8'h09, 16'h0001, 16'd0);
    status_in_ack();
    check_val("dfu_detach", int'(dfu_detach), 0);
    usb_reset = 1'b1;
    @(negedge clk);
    usb_reset = 1'b0;
    seen      = 1'b0;
    repeat (CLKS_PER_MS + 2) begin
      #5;
      if (dfu_detach) seen = 1'b1;
      @(negedge clk);
    end
    check_val("dfu_detach", int'(seen), 1);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
verilog/usb_dfu_pkg.sv
verilog/setup_if.sv
verilog/in_load_if.sv
verilog/setup_capture.sv
verilog/ctrl_xfr_fsm.sv
verilog/dfu_request_unit.sv
verilog/in_data_source.sv
verilog/detach_timer.sv
verilog/usb_dfu_ctrl_ep.sv
tests/usb_dfu_ctrl_ep_checker.sv
tests/usb_dfu_ctrl_ep_tb.sv

//--- run.sh
#!/bin/sh
# build and run the DFU control endpoint testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f \
  --top-module usb_dfu_ctrl_ep_tb -o usb_dfu_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/usb_dfu_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "TEST RESULT: PASS"; then
  exit 0
fi
exit 1
